/* list.f */
+incdir+source
source/hbm_reader_pkg.sv
source/read_ctrl.sv
source/param_regs.sv
source/ar_gen.sv
source/rdata_fifo.sv
source/pair_merge.sv
source/hbm_pair_reader.sv
tests/tb_checker.sv
tests/tb_hbm_pair_reader.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_hbm_pair_reader -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Testbench passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* source/ar_gen.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module ar_gen #(
    parameter int CH_ID = 0     // becomes arid
) (
    input  logic                        hbm_clk,
    input  logic                        hbm_rstn,
    input  hbm_reader_pkg::ch_op_t      op_i,
    input  hbm_reader_pkg::hbm_addr_t   base_addr_i,
    input  logic [`STRIDE_W-1:0]        stride_i,
    input  hbm_reader_pkg::burst_cnt_t  num_bursts_i,
    input  logic                        arready_i,
    output logic                        arvalid_o,
    output hbm_reader_pkg::hbm_addr_t   araddr_o,
    output logic [7:0]                  arlen_o,
    output logic [`ID_W-1:0]            arid_o,
    output logic                        issued_o
);
    import hbm_reader_pkg::*;

    hbm_addr_t   addr_q;        // next request address
    burst_cnt_t  remain_q;      // requests still to issue
    logic        ar_fire;

    // held high through stalls, remain only moves on a transfer
    assign arvalid_o = (op_i == OP_RUN) && (remain_q != '0);
    assign ar_fire   = arvalid_o && arready_i;

    assign araddr_o  = addr_q;
    assign arlen_o   = 8'(`BURST_LEN - 1);
    assign arid_o    = `ID_W'(CH_ID);
    assign issued_o  = (remain_q == '0);

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            remain_q <= '0;
        end else if (op_i == OP_LOAD) begin
            remain_q <= num_bursts_i;
        end else if (ar_fire) begin
            remain_q <= remain_q - 1'b1;
        end
    end

    // address walk, base + k * stride
    always_ff @(posedge hbm_clk) begin
        if (op_i == OP_LOAD) addr_q <= base_addr_i;
        else if (ar_fire)    addr_q <= addr_q + `HBM_ADDR_W'(stride_i);
    end

    // bus rule, request held until accepted
    a_ar_stable: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

endmodule

/* source/hbm_pair_reader.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module hbm_pair_reader (
    input  logic                        hbm_clk,
    input  logic                        hbm_rstn,
    input  logic                        params_valid_i,
    input  logic [`PARAM_W-1:0]         params_i,
    // ch0 read address / data
    output logic                        ch0_arvalid_o,
    input  logic                        ch0_arready_i,
    output hbm_reader_pkg::hbm_addr_t   ch0_araddr_o,
    output logic [7:0]                  ch0_arlen_o,
    output logic [`ID_W-1:0]            ch0_arid_o,
    input  logic                        ch0_rvalid_i,
    input  hbm_reader_pkg::beat_t       ch0_rdata_i,
    input  logic                        ch0_rlast_i,
    output logic                        ch0_rready_o,
    // ch1 read address / data
    output logic                        ch1_arvalid_o,
    input  logic                        ch1_arready_i,
    output hbm_reader_pkg::hbm_addr_t   ch1_araddr_o,
    output logic [7:0]                  ch1_arlen_o,
    output logic [`ID_W-1:0]            ch1_arid_o,
    input  logic                        ch1_rvalid_i,
    input  hbm_reader_pkg::beat_t       ch1_rdata_i,
    input  logic                        ch1_rlast_i,
    output logic                        ch1_rready_o,
    // consumer
    input  logic                        out_afull_i,
    output logic                        out_valid_o,
    output hbm_reader_pkg::word_t       out_data_o,
    output logic                        busy_o,
    output logic                        done_o
);
    import hbm_reader_pkg::*;

    logic                   capture;
    ch_op_t                 ch_op;
    hbm_addr_t              base_addr;
    burst_cnt_t             num_bursts;
    logic [`STRIDE_W-1:0]   stride;
    logic                   ch0_issued, ch1_issued;
    beat_t                  ch0_dout, ch1_dout;
    logic                   ch0_empty, ch1_empty;
    logic                   pop;

    //////////////////////////////
    // control
    //////////////////////////////
    read_ctrl read_ctrl_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .params_valid_i (params_valid_i),
        .ch0_issued_i   (ch0_issued),
        .ch1_issued_i   (ch1_issued),
        .out_valid_i    (out_valid_o),     // counts words toward done
        .num_bursts_i   (num_bursts),
        .capture_o      (capture),
        .ch_op_o        (ch_op),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    param_regs param_regs_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .capture_i      (capture),
        .params_i       (params_i),
        .base_addr_o    (base_addr),
        .num_bursts_o   (num_bursts),
        .stride_o       (stride)
    );

    //////////////////////////////
    // address side, lock step
    //////////////////////////////
    ar_gen #(.CH_ID(0)) ar_gen_ch0_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .op_i           (ch_op),
        .base_addr_i    (base_addr),
        .stride_i       (stride),
        .num_bursts_i   (num_bursts),
        .arready_i      (ch0_arready_i),
        .arvalid_o      (ch0_arvalid_o),
        .araddr_o       (ch0_araddr_o),
        .arlen_o        (ch0_arlen_o),
        .arid_o         (ch0_arid_o),
        .issued_o       (ch0_issued)
    );

    ar_gen #(.CH_ID(1)) ar_gen_ch1_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .op_i           (ch_op),
        .base_addr_i    (base_addr),        // same address on both channels
        .stride_i       (stride),
        .num_bursts_i   (num_bursts),
        .arready_i      (ch1_arready_i),
        .arvalid_o      (ch1_arvalid_o),
        .araddr_o       (ch1_araddr_o),
        .arlen_o        (ch1_arlen_o),
        .arid_o         (ch1_arid_o),
        .issued_o       (ch1_issued)
    );

    //////////////////////////////
    // data side
    //////////////////////////////
    rdata_fifo rdata_fifo_ch0_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .rvalid_i       (ch0_rvalid_i),
        .rdata_i        (ch0_rdata_i),
        .rlast_i        (ch0_rlast_i),
        .rready_o       (ch0_rready_o),
        .pop_i          (pop),
        .dout_o         (ch0_dout),
        .empty_o        (ch0_empty)
    );

    rdata_fifo rdata_fifo_ch1_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .rvalid_i       (ch1_rvalid_i),
        .rdata_i        (ch1_rdata_i),
        .rlast_i        (ch1_rlast_i),
        .rready_o       (ch1_rready_o),
        .pop_i          (pop),
        .dout_o         (ch1_dout),
        .empty_o        (ch1_empty)
    );

    pair_merge pair_merge_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .ch0_empty_i    (ch0_empty),
        .ch1_empty_i    (ch1_empty),
        .ch0_data_i     (ch0_dout),
        .ch1_data_i     (ch1_dout),
        .out_afull_i    (out_afull_i),
        .pop_o          (pop),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o)
    );

endmodule

/* source/hbm_reader_macros.svh */
`ifndef HBM_READER_MACROS_SVH
`define HBM_READER_MACROS_SVH

// bus widths
`define HBM_ADDR_W       33      // 8G byte space
`define HBM_DATA_W       256     // one channel beat
`define OUT_DATA_W       512     // ch1 beat over ch0 beat
`define ID_W             6
`define BURST_LEN        4       // beats per burst, arlen = BURST_LEN-1
`define BURST_CNT_W      16
`define STRIDE_W         32
`define WORD_CNT_W       18      // burst count times BURST_LEN

// read data fifo
`define FIFO_DEPTH_BITS  4       // 16 entries
`define FIFO_AFULL       8       // rready drops at this fill

// parameter word layout
`define PARAM_W          128
`define PRM_ADDR_LSB     0
`define PRM_BURSTS_LSB   64
`define PRM_STRIDE_LSB   96

`endif

/* source/hbm_reader_pkg.sv */
`include "hbm_reader_macros.svh"

package hbm_reader_pkg;

    // controller states
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ISSUE,
        CTRL_DRAIN,
        CTRL_DONE
    } ctrl_state_t;

    // controller to address generator opcodes
    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,    // take base, stride, count
        OP_RUN      // issue bursts
    } ch_op_t;

    typedef logic [`HBM_ADDR_W-1:0]  hbm_addr_t;
    typedef logic [`BURST_CNT_W-1:0] burst_cnt_t;
    typedef logic [`HBM_DATA_W-1:0]  beat_t;
    typedef logic [`OUT_DATA_W-1:0]  word_t;

endpackage

/* source/pair_merge.sv */
`timescale 1ns/100ps

module pair_merge (
    input  logic                    hbm_clk,
    input  logic                    hbm_rstn,
    input  logic                    ch0_empty_i,
    input  logic                    ch1_empty_i,
    input  hbm_reader_pkg::beat_t   ch0_data_i,
    input  hbm_reader_pkg::beat_t   ch1_data_i,
    input  logic                    out_afull_i,
    output logic                    pop_o,
    output logic                    out_valid_o,
    output hbm_reader_pkg::word_t   out_data_o
);
    import hbm_reader_pkg::*;

    logic   pop_q;          // fifo douts valid this cycle
    logic   out_valid_q;
    word_t  out_data_q;

    // joint pop keeps ch0 and ch1 beats paired
    assign pop_o = !ch0_empty_i && !ch1_empty_i && !out_afull_i;

    //////////////////////////////
    // pop -> valid -> joined word
    //////////////////////////////
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            pop_q       <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            pop_q       <= pop_o;
            out_valid_q <= pop_q;   // n+2 after the pop decision
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (pop_q) out_data_q <= {ch1_data_i, ch0_data_i};   // ch1 on top
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

endmodule

/* source/param_regs.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module param_regs (
    input  logic                        hbm_clk,
    input  logic                        hbm_rstn,
    input  logic                        capture_i,
    input  logic [`PARAM_W-1:0]         params_i,
    output hbm_reader_pkg::hbm_addr_t   base_addr_o,
    output hbm_reader_pkg::burst_cnt_t  num_bursts_o,
    output logic [`STRIDE_W-1:0]        stride_o
);

    logic [`HBM_ADDR_W-1:0]  base_addr_q;
    logic [`BURST_CNT_W-1:0] num_bursts_q;
    logic [`STRIDE_W-1:0]    stride_q;

    //////////////////////////////
    // field capture
    //////////////////////////////
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            base_addr_q  <= '0;
            num_bursts_q <= '0;
            stride_q     <= '0;
        end else if (capture_i) begin
            base_addr_q  <= params_i[`PRM_ADDR_LSB   +: `HBM_ADDR_W];   // byte address
            num_bursts_q <= params_i[`PRM_BURSTS_LSB +: `BURST_CNT_W];  // bursts per channel
            stride_q     <= params_i[`PRM_STRIDE_LSB +: `STRIDE_W];     // bytes between bursts
        end
        // otherwise hold, fields live on between runs
    end

    assign base_addr_o  = base_addr_q;
    assign num_bursts_o = num_bursts_q;
    assign stride_o     = stride_q;

endmodule

/* source/rdata_fifo.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module rdata_fifo (
    input  logic                    hbm_clk,
    input  logic                    hbm_rstn,
    input  logic                    rvalid_i,
    input  hbm_reader_pkg::beat_t   rdata_i,
    input  logic                    rlast_i,
    output logic                    rready_o,
    input  logic                    pop_i,
    output hbm_reader_pkg::beat_t   dout_o,
    output logic                    empty_o
);
    import hbm_reader_pkg::*;

    beat_t                      mem [0:(1 << `FIFO_DEPTH_BITS)-1];
    beat_t                      dout_q;
    logic [`FIFO_DEPTH_BITS-1:0] wr_ptr, rd_ptr;
    logic [`FIFO_DEPTH_BITS:0]   count;
    logic [7:0]                  beat_cnt;     // position inside current burst
    logic                        rready_q;
    logic                        wr, rd, full, afull;

    assign wr      = rvalid_i && rready_q;
    assign rd      = pop_i && !empty_o;
    assign empty_o = (count == '0);
    assign full    = (count == (`FIFO_DEPTH_BITS+1)'(1 << `FIFO_DEPTH_BITS));
    assign afull   = (count >= (`FIFO_DEPTH_BITS+1)'(`FIFO_AFULL));  // headroom for 1 late beat
    assign rready_o = rready_q;
    assign dout_o   = dout_q;

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            beat_cnt <= '0;
            rready_q <= 1'b0;
        end else begin
            rready_q <= !afull;         // back-pressure, one cycle late
            if (wr) wr_ptr <= wr_ptr + 1'b1;
            if (rd) rd_ptr <= rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr) beat_cnt <= (beat_cnt == 8'(`BURST_LEN - 1)) ? '0 : beat_cnt + 1'b1;
        end
    end

    // storage and registered read
    always_ff @(posedge hbm_clk) begin
        if (wr) mem[wr_ptr] <= rdata_i;
        if (rd) dout_q      <= mem[rd_ptr];   // valid the cycle after pop
    end

    a_rlast_pos: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        wr |-> rlast_i == (beat_cnt == 8'(`BURST_LEN - 1)));
    a_no_overflow: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        wr |-> !full);

endmodule

/* source/read_ctrl.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module read_ctrl (
    input  logic                        hbm_clk,
    input  logic                        hbm_rstn,
    input  logic                        params_valid_i,
    input  logic                        ch0_issued_i,
    input  logic                        ch1_issued_i,
    input  logic                        out_valid_i,
    input  hbm_reader_pkg::burst_cnt_t  num_bursts_i,
    output logic                        capture_o,
    output hbm_reader_pkg::ch_op_t      ch_op_o,
    output logic                        busy_o,
    output logic                        done_o
);
    import hbm_reader_pkg::*;

    ctrl_state_t             state;
    ch_op_t                  ch_op;
    logic [`WORD_CNT_W-1:0]  word_cnt;     // words seen this run
    logic [`WORD_CNT_W-1:0]  word_cnt_nxt;
    logic [`WORD_CNT_W-1:0]  word_target;

    assign busy_o    = (state == CTRL_ISSUE) || (state == CTRL_DRAIN);
    assign done_o    = (state == CTRL_DONE);   // low again with busy
    assign capture_o = params_valid_i && !busy_o;  // strobes ignored while busy
    assign ch_op_o   = ch_op;

    assign word_target  = `WORD_CNT_W'(num_bursts_i) * `WORD_CNT_W'(`BURST_LEN);
    assign word_cnt_nxt = word_cnt + `WORD_CNT_W'(out_valid_i);

    //////////////////////////////
    // run sequencer
    //////////////////////////////
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            state    <= CTRL_IDLE;
            ch_op    <= OP_NONE;
            word_cnt <= '0;
        end else begin
            case (state)
                CTRL_IDLE, CTRL_DONE: begin
                    ch_op <= OP_NONE;
                    state <= CTRL_IDLE;
                    if (capture_o) begin
                        state    <= CTRL_ISSUE;
                        ch_op    <= OP_LOAD;     // generators load next cycle
                        word_cnt <= '0;
                    end
                end
                CTRL_ISSUE: begin
                    word_cnt <= word_cnt_nxt;    // words can come out early
                    // issued flags are stale during the load cycle
                    if (ch_op == OP_RUN && ch0_issued_i && ch1_issued_i) begin
                        state <= CTRL_DRAIN;
                        ch_op <= OP_NONE;
                    end else begin
                        ch_op <= OP_RUN;
                    end
                end
                CTRL_DRAIN: begin
                    word_cnt <= word_cnt_nxt;
                    if (word_cnt_nxt == word_target) state <= CTRL_DONE;
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // done only at the end of a drain, with every request issued
    a_done_after_drain: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        done_o |-> $past(state) == CTRL_DRAIN && $past(ch0_issued_i && ch1_issued_i));

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module tb_checker (
    input  logic                        hbm_clk,
    input  logic                        hbm_rstn,
    input  logic                        params_valid_i,
    input  logic [`PARAM_W-1:0]         params_i,
    input  logic [1:0]                  arvalid_i,
    input  logic [1:0]                  arready_i,
    input  logic [`HBM_ADDR_W-1:0]      araddr_i [2],
    input  logic [7:0]                  arlen_i [2],
    input  logic [`ID_W-1:0]            arid_i [2],
    input  logic [1:0]                  rready_i,
    input  logic                        out_afull_i,
    input  logic                        out_valid_i,
    input  logic [`OUT_DATA_W-1:0]      out_data_i,
    input  logic                        busy_i,
    input  logic                        done_i,
    input  logic                        end_i,
    output int                          err_cnt_o,
    output int                          words_o
);
    import hbm_reader_pkg::*;

    hbm_addr_t   base;          // fields of the accepted run
    burst_cnt_t  bursts;
    logic [31:0] stride;
    hbm_addr_t   exp_addr;
    int          ar_k [2];      // requests seen per channel
    int          word_idx, target, runs, dones, afull_words, last_word_cyc;
    int          cyc = 0;
    int          err_cnt = 0;
    int          words = 0;
    logic        in_run, prev_afull, closed;

    assign err_cnt_o = err_cnt;
    assign words_o   = words;

    // beat j of the burst at a on channel c
    function automatic beat_t beat_value(hbm_addr_t a, int j, int c);
        return {4{7'(c), a, 8'(j), 16'hbe47}};
    endfunction

    // word w of the run, ch1 beat over ch0 beat
    function automatic word_t expected_word(int w);
        hbm_addr_t a;
        a = base + hbm_addr_t'(w / `BURST_LEN) * hbm_addr_t'(stride);
        return {beat_value(a, w % `BURST_LEN, 1), beat_value(a, w % `BURST_LEN, 0)};
    endfunction

    task automatic mismatch(string test, logic [`OUT_DATA_W-1:0] expected,
                            logic [`OUT_DATA_W-1:0] actual);
        err_cnt++;
        $display("error %s: expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic protocol_fault(string msg);
        err_cnt++;
        $display("%s", msg);
    endtask

    //////////////////////////////
    // sampled on the rising edge
    //////////////////////////////
    always @(posedge hbm_clk) begin
        cyc++;
        if (!hbm_rstn) begin
            // reset values settle after the first edge
            if (cyc > 1 && (busy_i || done_i || out_valid_i
                            || arvalid_i != 2'b00 || rready_i != 2'b00))
                protocol_fault("outputs not low while reset is held");
            in_run        = 1'b0;
            prev_afull    = 1'b0;
            closed        = 1'b0;
            runs          = 0;
            dones         = 0;
            afull_words   = 0;
            last_word_cyc = -10;
        end else begin
            if (runs == 0 && (busy_i || done_i || out_valid_i || arvalid_i != 2'b00))
                protocol_fault("outputs active after reset before the first strobe");
            if (in_run && !done_i && !busy_i)
                protocol_fault("busy_o low in the middle of a run");
            if (!in_run && runs > 0 && busy_i)
                protocol_fault("busy_o high between runs");
            // end of run, done one cycle after the last word
            if (done_i) begin
                if (!in_run) begin
                    protocol_fault("done_o pulsed outside a run");
                end else begin
                    if (word_idx != target) mismatch("word count at done", target, word_idx);
                    if (last_word_cyc != cyc - 1)
                        protocol_fault("done_o not 1 cycle after the last word");
                end
                if (busy_i) protocol_fault("busy_o still high together with done_o");
                in_run = 1'b0;
                dones++;
            end else if (in_run && word_idx == target && last_word_cyc == cyc - 1) begin
                protocol_fault("no done_o 1 cycle after the last word");
            end
            // read requests, base + k * stride
            for (int c = 0; c < 2; c++) begin
                if (arvalid_i[c] && arready_i[c]) begin
                    if (!in_run || ar_k[c] >= int'(bursts)) begin
                        protocol_fault($sformatf("ch%0d request beyond the burst count", c));
                    end else begin
                        exp_addr = base + hbm_addr_t'(ar_k[c]) * hbm_addr_t'(stride);
                        if (araddr_i[c] !== exp_addr)
                            mismatch($sformatf("ch%0d araddr", c), exp_addr, araddr_i[c]);
                        if (arlen_i[c] !== 8'(`BURST_LEN - 1))
                            mismatch($sformatf("ch%0d arlen", c), `BURST_LEN - 1, arlen_i[c]);
                        if (arid_i[c] !== `ID_W'(c))
                            mismatch($sformatf("ch%0d arid", c), c, arid_i[c]);
                    end
                    ar_k[c]++;
                end
            end
            // joined words in request order
            if (out_afull_i && !prev_afull) afull_words = 0;
            if (out_valid_i) begin
                if (!in_run || word_idx >= target)
                    protocol_fault("output word outside a run or past the burst count");
                else if (out_data_i !== expected_word(word_idx))
                    mismatch("output word", expected_word(word_idx), out_data_i);
                if (out_afull_i) begin
                    afull_words++;
                    if (afull_words == 4) protocol_fault("more than 3 words after out_afull_i rose");
                end
                word_idx++;
                words++;
                last_word_cyc = cyc;
            end
            prev_afull = out_afull_i;
            // strobe taken only while idle
            if (params_valid_i && !in_run) begin
                base     = params_i[`PRM_ADDR_LSB +: `HBM_ADDR_W];
                bursts   = params_i[`PRM_BURSTS_LSB +: `BURST_CNT_W];
                stride   = params_i[`PRM_STRIDE_LSB +: 32];
                target   = int'(bursts) * `BURST_LEN;
                word_idx = 0;
                ar_k[0]  = 0;
                ar_k[1]  = 0;
                in_run   = 1'b1;
                runs++;
            end
            if (end_i && !closed) begin
                closed = 1'b1;
                if (in_run) protocol_fault("a run was still open at the end of the test");
                if (dones != runs) mismatch("done pulse count", runs, dones);
            end
        end
    end

endmodule

/* tests/tb_hbm_pair_reader.sv */
`timescale 1ns/100ps
`include "hbm_reader_macros.svh"

module tb_hbm_pair_reader;
    import hbm_reader_pkg::*;

    localparam int NUM_RUNS = 6;

    logic                     hbm_clk = 1'b0;
    logic                     hbm_rstn;
    logic                     params_valid;
    logic [`PARAM_W-1:0]      params;
    logic [1:0]               arready = 2'b00;
    logic [1:0]               rvalid = 2'b00;
    logic [1:0]               rlast = 2'b00;
    beat_t                    rdata [2] = '{default: '0};
    logic                     out_afull = 1'b0;
    logic                     end_of_test;
    wire  [1:0]               arvalid, rready;
    wire  [`HBM_ADDR_W-1:0]   araddr [2];
    wire  [7:0]               arlen [2];
    wire  [`ID_W-1:0]         arid [2];
    wire                      out_valid, busy, done;
    wire  [`OUT_DATA_W-1:0]   out_data;
    int                       err_cnt, word_cnt;

    // memory model, requests kept in order per channel
    hbm_addr_t                req_addr [2][0:255];
    int                       req_wr [2] = '{0, 0};
    int                       req_rd [2] = '{0, 0};
    int                       beat_j [2] = '{0, 0};
    int                       gap [2] = '{0, 0};
    logic [1:0]               beat_taken = 2'b00;   // beat goes at the next rising edge

    logic [`PARAM_W-1:0]      run_params [NUM_RUNS];
    int                       cycle_cnt = 0;
    int                       cycle_limit = 0;

    always #2 hbm_clk = ~hbm_clk;    // 4 ns period

    hbm_pair_reader hbm_pair_reader_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .params_valid_i (params_valid),
        .params_i       (params),
        .ch0_arvalid_o  (arvalid[0]),
        .ch0_arready_i  (arready[0]),
        .ch0_araddr_o   (araddr[0]),
        .ch0_arlen_o    (arlen[0]),
        .ch0_arid_o     (arid[0]),
        .ch0_rvalid_i   (rvalid[0]),
        .ch0_rdata_i    (rdata[0]),
        .ch0_rlast_i    (rlast[0]),
        .ch0_rready_o   (rready[0]),
        .ch1_arvalid_o  (arvalid[1]),
        .ch1_arready_i  (arready[1]),
        .ch1_araddr_o   (araddr[1]),
        .ch1_arlen_o    (arlen[1]),
        .ch1_arid_o     (arid[1]),
        .ch1_rvalid_i   (rvalid[1]),
        .ch1_rdata_i    (rdata[1]),
        .ch1_rlast_i    (rlast[1]),
        .ch1_rready_o   (rready[1]),
        .out_afull_i    (out_afull),
        .out_valid_o    (out_valid),
        .out_data_o     (out_data),
        .busy_o         (busy),
        .done_o         (done)
    );

    tb_checker checker_inst (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .params_valid_i (params_valid),
        .params_i       (params),
        .arvalid_i      (arvalid),
        .arready_i      (arready),
        .araddr_i       (araddr),
        .arlen_i        (arlen),
        .arid_i         (arid),
        .rready_i       (rready),
        .out_afull_i    (out_afull),
        .out_valid_i    (out_valid),
        .out_data_i     (out_data),
        .busy_i         (busy),
        .done_i         (done),
        .end_i          (end_of_test),
        .err_cnt_o      (err_cnt),
        .words_o        (word_cnt)
    );

    // beat j of the burst at a on channel c
    function automatic beat_t beat_value(hbm_addr_t a, int j, int c);
        return {4{7'(c), a, 8'(j), 16'hbe47}};
    endfunction

    //////////////////////////////
    // memory channel model
    //////////////////////////////
    task automatic serve_channel(int c);
        if (beat_taken[c]) begin     // retire last beat
            rvalid[c] = 1'b0;
            beat_j[c] = beat_j[c] + 1;
            if (beat_j[c] == `BURST_LEN) begin
                beat_j[c] = 0;
                req_rd[c] = req_rd[c] + 1;
            end
        end
        if (!rvalid[c] && req_rd[c] != req_wr[c]) begin
            if (gap[c] > 0) begin
                gap[c] = gap[c] - 1;     // random idle before the beat
            end else begin
                rdata[c]  = beat_value(req_addr[c][req_rd[c]], beat_j[c], c);
                rlast[c]  = (beat_j[c] == `BURST_LEN - 1);
                rvalid[c] = 1'b1;
                gap[c]    = $urandom % 3;
            end
        end
        beat_taken[c] = rvalid[c] && rready[c];   // rready holds until the edge
        // request after data, so no beat comes before its address
        arready[c] = ($urandom % 4) != 0;
        if (arvalid[c] && arready[c]) begin
            req_addr[c][req_wr[c]] = araddr[c];
            req_wr[c] = req_wr[c] + 1;
        end
    endtask

    // memory and consumer, started once reset is gone
    always @(negedge hbm_clk) begin
        if (cycle_cnt > 2) begin
            serve_channel(0);
            serve_channel(1);
            if ($urandom % 8 == 0) out_afull = !out_afull;   // random back-pressure
        end
    end

    // watchdog
    always @(posedge hbm_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: runs did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d, words checked: %0d", err_cnt, word_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        logic [`PARAM_W-1:0] junk [NUM_RUNS];
        int                  junk_at [NUM_RUNS];
        int                  n;
        void'($urandom(32'h0269_deac));
        hbm_rstn     = 1'b0;
        params_valid = 1'b0;
        params       = '0;
        end_of_test  = 1'b0;
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_params[r] = {$urandom, $urandom, $urandom, $urandom};
            run_params[r][`PRM_BURSTS_LSB +: `BURST_CNT_W] = `BURST_CNT_W'(1 + $urandom % 12);
            junk[r]    = {$urandom, $urandom, $urandom, $urandom};   // strobed while busy
            junk_at[r] = 1 + $urandom % 6;
            cycle_limit = cycle_limit + 200
                + 40 * `BURST_LEN * int'(run_params[r][`PRM_BURSTS_LSB +: `BURST_CNT_W]);
        end
        repeat (2) @(negedge hbm_clk);
        hbm_rstn = 1'b1;
        repeat (3) @(negedge hbm_clk);   // idle window after reset
        for (int r = 0; r < NUM_RUNS; r++) begin
            params_valid = 1'b1;
            params       = run_params[r];
            n = 0;
            do begin
                @(negedge hbm_clk);
                n++;
                params_valid = (n == junk_at[r]) && busy;
                params       = (n == junk_at[r]) ? junk[r] : run_params[r];
            end while (!done);
            params_valid = 1'b0;
            repeat (3) @(negedge hbm_clk);
        end
        end_of_test = 1'b1;
        repeat (2) @(negedge hbm_clk);
        $display("errors: %0d, words checked: %0d", err_cnt, word_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
